/* verilog/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_slti    = 6'h0a,
		op_sltiu   = 6'h0b,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_lui     = 6'h0f,
		op_lb      = 6'h20,
		op_lh      = 6'h21,
		op_lw      = 6'h23,
		op_lbu     = 6'h24,
		op_lhu     = 6'h25,
		op_sb      = 6'h28,
		op_sh      = 6'h29,
		op_sw      = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_t;

	typedef enum logic [2:0] {
		alu_and  = 3'b000,
		alu_or   = 3'b001,
		alu_add  = 3'b010,
		alu_sltu = 3'b011,
		alu_xor  = 3'b100,
		alu_nor  = 3'b101,
		alu_sub  = 3'b110,
		alu_slt  = 3'b111
	} alu_op_t;

	typedef enum logic [8:0] {
		s_init = 9'b000000001,
		s_if   = 9'b000000010,
		s_iw   = 9'b000000100,
		s_id   = 9'b000001000,
		s_ex   = 9'b000010000,
		s_st   = 9'b000100000,
		s_ld   = 9'b001000000,
		s_rdw  = 9'b010000000,
		s_wb   = 9'b100000000
	} cpu_state_t;

	typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_t;
	typedef enum logic [1:0] {wb_alu, wb_load, wb_upper} wb_sel_t;

	typedef enum logic [1:0] {a_pc, a_pc4, a_opnd} alu_a_sel_t;
	typedef enum logic [1:0] {b_four, b_offset, b_opnd} alu_b_sel_t;
	typedef enum logic [1:0] {pc_seq, pc_target, pc_jump} pc_sel_t;

	typedef struct packed {
		opcode_t    opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		funct_t     funct;
	} r_fields_t;

	typedef struct packed {
		opcode_t     opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm16;
	} i_fields_t;

	typedef struct packed {
		opcode_t     opcode;
		logic [25:0] index;
	} j_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		j_fields_t j;
	} cpu_instr_t;

endpackage

/* verilog/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if (
	input logic clk
);
	import cpu_pkg::*;

	logic       ir_load;
	logic       opnd_load;
	alu_op_t    alu_op;
	alu_a_sel_t alu_a_sel;
	alu_b_sel_t alu_b_sel;
	pc_sel_t    pc_sel;
	logic       pc_write;
	logic       b_is_imm;
	logic       imm_zero_ext;
	logic       rf_wen;
	wb_sel_t    wb_sel;
	mem_size_t  mem_size;
	logic       load_unsigned;
	logic       mem_en;         // Request phase of a load or store
	cpu_instr_t instr;
	logic       alu_zero;

	modport ctl (
		output ir_load, opnd_load, alu_op, alu_a_sel, alu_b_sel, pc_sel, pc_write,
		output b_is_imm, imm_zero_ext, rf_wen, wb_sel, mem_size, load_unsigned, mem_en,
		input  instr, alu_zero
	);

	modport dp (
		input  ir_load, opnd_load, alu_a_sel, alu_b_sel, pc_sel, pc_write,
		input  b_is_imm, imm_zero_ext, rf_wen, wb_sel,
		output instr, alu_zero
	);

	modport mem (
		input clk, mem_size, load_unsigned, mem_en
	);

endinterface

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	input  cpu_pkg::alu_op_t op,
	output cpu_pkg::word_t   result,
	output logic             zero
);
	import cpu_pkg::*;

	always_comb begin
		case (op)
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_nor:  result = ~(a | b);
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
			alu_sltu: result = {31'b0, a < b};
			default:  result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  cpu_pkg::reg_addr_t raddr1,
	input  cpu_pkg::reg_addr_t raddr2,
	input  cpu_pkg::reg_addr_t waddr,
	input  logic               wen,
	input  cpu_pkg::word_t     wdata,
	output cpu_pkg::word_t     rdata1,
	output cpu_pkg::word_t     rdata2
);
	import cpu_pkg::*;

	word_t regs [1:31];   // No storage behind r0

	always_ff @(posedge clk) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* verilog/mem_align.sv */
`timescale 1ns/1ps

module mem_align (
	input  logic [1:0]     byte_offset,
	input  cpu_pkg::word_t store_src,
	input  cpu_pkg::word_t read_word,
	ctrl_if.mem            mem,
	output cpu_pkg::word_t write_data,
	output logic [3:0]     write_strb,
	output cpu_pkg::word_t load_value
);
	import cpu_pkg::*;

	logic [7:0]  load_byte;
	logic [15:0] load_half;

	// Store lanes are replicated, the strobe picks the live one
	always_comb begin
		case (mem.mem_size)
			size_byte: begin
				write_data = {4{store_src[7:0]}};
				write_strb = 4'b0001 << byte_offset;
			end
			size_half: begin
				write_data = {2{store_src[15:0]}};
				write_strb = byte_offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				write_data = store_src;
				write_strb = 4'b1111;
			end
		endcase
	end

	assign load_byte = read_word[8*byte_offset +: 8];
	assign load_half = byte_offset[1] ? read_word[31:16] : read_word[15:0];

	always_comb begin
		case (mem.mem_size)
			size_byte:
				load_value = mem.load_unsigned ? {24'b0, load_byte} : {{24{load_byte[7]}}, load_byte};
			size_half:
				load_value = mem.load_unsigned ? {16'b0, load_half} : {{16{load_half[15]}}, load_half};
			default:
				load_value = read_word;
		endcase
	end

	half_aligned: assert property (@(posedge mem.clk)
		mem.mem_en && mem.mem_size == size_half |-> !byte_offset[0]);
	word_aligned: assert property (@(posedge mem.clk)
		mem.mem_en && mem.mem_size == size_word |-> byte_offset == 2'b00);

endmodule

/* verilog/exec_datapath.sv */
`timescale 1ns/1ps

module exec_datapath #(
	parameter cpu_pkg::word_t reset_pc = '0
) (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::word_t     instruction,
	input  cpu_pkg::word_t     read_data,
	input  cpu_pkg::word_t     load_value,
	input  cpu_pkg::word_t     rs_data,
	input  cpu_pkg::word_t     rt_data,
	input  cpu_pkg::word_t     alu_result,
	input  logic               alu_zero_in,
	output cpu_pkg::word_t     pc,
	output cpu_pkg::word_t     address,
	output cpu_pkg::word_t     alu_a,
	output cpu_pkg::word_t     alu_b,
	output cpu_pkg::word_t     rf_wdata,
	output cpu_pkg::word_t     store_data,
	output cpu_pkg::word_t     read_word,
	output cpu_pkg::reg_addr_t rf_raddr1,
	output cpu_pkg::reg_addr_t rf_raddr2,
	output cpu_pkg::reg_addr_t rf_waddr,
	output logic [1:0]         byte_offset,
	ctrl_if.dp                 cif
);
	import cpu_pkg::*;

	cpu_instr_t ir;
	word_t      pc_plus4;
	word_t      opnd_a;
	word_t      opnd_b;
	word_t      target;
	word_t      store_reg;
	word_t      result;
	word_t      rdata_q;
	word_t      imm_ext;
	word_t      offset;

	assign imm_ext = cif.imm_zero_ext ? {16'b0, ir.i.imm16} : {{16{ir.i.imm16[15]}}, ir.i.imm16};
	assign offset  = {{14{ir.i.imm16[15]}}, ir.i.imm16, 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
		end else if (cif.pc_write) begin
			case (cif.pc_sel)
				pc_target: pc <= target;
				pc_jump:   pc <= {pc_plus4[31:28], ir.j.index, 2'b00};
				default:   pc <= pc_plus4;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cif.ir_load) begin
			ir       <= instruction;
			pc_plus4 <= alu_result;   // PC+4 still on the ALU
		end
		if (cif.opnd_load) begin
			opnd_a    <= rs_data;
			opnd_b    <= cif.b_is_imm ? imm_ext : rt_data;
			target    <= alu_result;
			store_reg <= rt_data;
		end
		if (cif.alu_a_sel == a_opnd)
			result <= alu_result;     // Execute step
		if (!cif.rf_wen)
			rdata_q <= read_data;     // Held through write-back
	end

	always_comb begin
		case (cif.alu_a_sel)
			a_pc4:   alu_a = pc_plus4;
			a_opnd:  alu_a = opnd_a;
			default: alu_a = pc;
		endcase
		case (cif.alu_b_sel)
			b_offset: alu_b = offset;
			b_opnd:   alu_b = opnd_b;
			default:  alu_b = 32'd4;
		endcase
	end

	always_comb begin
		case (cif.wb_sel)
			wb_load:  rf_wdata = load_value;
			wb_upper: rf_wdata = {ir.i.imm16, 16'b0};
			default:  rf_wdata = result;
		endcase
	end

	assign rf_raddr1  = ir.i.rs;
	assign rf_raddr2  = ir.i.rt;
	assign rf_waddr   = (ir.r.opcode == op_special) ? ir.r.rd : ir.i.rt;
	assign address    = {result[31:2], 2'b00};
	assign byte_offset = result[1:0];
	assign store_data = store_reg;
	assign read_word  = rdata_q;

	assign cif.instr    = ir;
	assign cif.alu_zero = alu_zero_in;

endmodule

/* verilog/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control (
	input  logic clk,
	input  logic rst,
	input  logic inst_req_ready,
	input  logic inst_valid,
	input  logic mem_req_ready,
	input  logic read_data_valid,
	output logic inst_req_valid,
	output logic inst_ready,
	output logic mem_read,
	output logic mem_write,
	output logic read_data_ready,
	ctrl_if.ctl  cif
);
	import cpu_pkg::*;

	cpu_state_t state;
	cpu_state_t next_state;
	opcode_t    op;
	funct_t     fn;
	alu_op_t    ex_op;
	logic       is_rtype;
	logic       is_icalc;
	logic       is_load;
	logic       is_store;
	logic       is_branch;
	logic       is_jump;
	logic       is_nop;
	logic       taken;

	assign op        = cif.instr.i.opcode;
	assign fn        = cif.instr.r.funct;
	assign is_rtype  = (op == op_special);
	assign is_icalc  = op inside {op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui};
	assign is_load   = op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
	assign is_store  = op inside {op_sb, op_sh, op_sw};
	assign is_branch = op inside {op_beq, op_bne};
	assign is_jump   = (op == op_j);
	assign is_nop    = (cif.instr == '0);
	assign taken     = is_branch && (cif.alu_zero ^ (op == op_bne));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_init;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			s_init: next_state = s_if;
			s_if:   next_state = inst_req_ready ? s_iw : s_if;
			s_iw:   next_state = inst_valid ? s_id : s_iw;
			s_id:   next_state = is_nop ? s_if : s_ex;
			s_ex: begin
				if (is_store)
					next_state = s_st;
				else if (is_load)
					next_state = s_ld;
				else if (is_rtype || is_icalc)
					next_state = s_wb;
				else
					next_state = s_if;
			end
			s_st:   next_state = mem_req_ready ? s_if : s_st;
			s_ld:   next_state = mem_req_ready ? s_rdw : s_ld;
			s_rdw:  next_state = read_data_valid ? s_wb : s_rdw;
			s_wb:   next_state = s_if;
			default: next_state = s_init;
		endcase
	end

	always_comb begin
		ex_op = alu_add;
		if (is_rtype) begin
			case (fn)
				fn_subu: ex_op = alu_sub;
				fn_and:  ex_op = alu_and;
				fn_or:   ex_op = alu_or;
				fn_xor:  ex_op = alu_xor;
				fn_nor:  ex_op = alu_nor;
				fn_slt:  ex_op = alu_slt;
				fn_sltu: ex_op = alu_sltu;
				default: ex_op = alu_add;
			endcase
		end else begin
			case (op)
				op_slti:        ex_op = alu_slt;
				op_sltiu:       ex_op = alu_sltu;
				op_andi:        ex_op = alu_and;
				op_ori:         ex_op = alu_or;
				op_xori:        ex_op = alu_xor;
				op_beq, op_bne: ex_op = alu_sub;   // Equality through the zero flag
				default:        ex_op = alu_add;
			endcase
		end
	end

	// One ALU for PC+4 in fetch, the branch target in decode and the operation in execute
	always_comb begin
		cif.alu_a_sel = a_pc;
		cif.alu_b_sel = b_four;
		cif.alu_op    = alu_add;
		cif.pc_sel    = pc_seq;
		cif.pc_write  = 1'b0;
		case (state)
			s_id: begin
				cif.alu_a_sel = a_pc4;
				cif.alu_b_sel = b_offset;
				cif.pc_write  = is_nop;
			end
			s_ex: begin
				cif.alu_a_sel = a_opnd;
				cif.alu_b_sel = b_opnd;
				cif.alu_op    = ex_op;
				if (!is_store && !is_load && !is_rtype && !is_icalc) begin
					cif.pc_write = 1'b1;
					cif.pc_sel   = is_jump ? pc_jump : (taken ? pc_target : pc_seq);
				end
			end
			s_st: cif.pc_write = mem_req_ready;
			s_wb: cif.pc_write = 1'b1;
			default: begin
			end
		endcase
	end

	always_comb begin
		case (op)
			op_lb, op_lbu, op_sb: cif.mem_size = size_byte;
			op_lh, op_lhu, op_sh: cif.mem_size = size_half;
			default:              cif.mem_size = size_word;
		endcase
	end

	assign cif.ir_load       = (state == s_iw) && inst_valid;
	assign cif.opnd_load     = (state == s_id);
	assign cif.b_is_imm      = !is_rtype && !is_branch;
	assign cif.imm_zero_ext  = op inside {op_andi, op_ori, op_xori};
	assign cif.rf_wen        = (state == s_wb);
	assign cif.wb_sel        = (op == op_lui) ? wb_upper : (is_load ? wb_load : wb_alu);
	assign cif.load_unsigned = op inside {op_lbu, op_lhu};
	assign cif.mem_en        = (state == s_st) || (state == s_ld);

	assign inst_req_valid  = (state == s_if);
	assign inst_ready      = (state == s_iw) || (state == s_init);
	assign mem_read        = (state == s_ld);
	assign mem_write       = (state == s_st);
	assign read_data_ready = (state == s_rdw) || (state == s_init);

	state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(state));
	mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_write && mem_read));

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
	parameter cpu_pkg::word_t reset_pc = '0
) (
	input  logic               clk,
	input  logic               rst,
	output logic               inst_req_valid,
	input  logic               inst_req_ready,
	output cpu_pkg::word_t     pc,
	input  cpu_pkg::word_t     instruction,
	input  logic               inst_valid,
	output logic               inst_ready,
	output cpu_pkg::word_t     address,
	output logic               mem_write,
	output cpu_pkg::word_t     write_data,
	output logic [3:0]         write_strb,
	output logic               mem_read,
	input  logic               mem_req_ready,
	input  cpu_pkg::word_t     read_data,
	input  logic               read_data_valid,
	output logic               read_data_ready,
	output logic               retire_wen,
	output cpu_pkg::reg_addr_t retire_waddr,
	output cpu_pkg::word_t     retire_wdata,
	output cpu_pkg::word_t     retire_pc
);
	import cpu_pkg::*;

	word_t      alu_a;
	word_t      alu_b;
	word_t      alu_result;
	logic       alu_zero;
	word_t      rs_data;
	word_t      rt_data;
	word_t      load_value;
	word_t      store_data;
	word_t      rf_wdata;
	word_t      read_word;
	reg_addr_t  rf_raddr1;
	reg_addr_t  rf_raddr2;
	reg_addr_t  rf_waddr;
	logic [1:0] byte_offset;

	ctrl_if cif (.clk(clk));

	cpu_control u_control (
		.clk(clk), .rst(rst),
		.inst_req_ready(inst_req_ready), .inst_valid(inst_valid),
		.mem_req_ready(mem_req_ready), .read_data_valid(read_data_valid),
		.inst_req_valid(inst_req_valid), .inst_ready(inst_ready),
		.mem_read(mem_read), .mem_write(mem_write),
		.read_data_ready(read_data_ready), .cif(cif.ctl)
	);

	exec_datapath #(.reset_pc(reset_pc)) u_datapath (
		.clk(clk), .rst(rst), .instruction(instruction), .read_data(read_data),
		.load_value(load_value), .rs_data(rs_data), .rt_data(rt_data),
		.alu_result(alu_result), .alu_zero_in(alu_zero), .pc(pc), .address(address),
		.alu_a(alu_a), .alu_b(alu_b), .rf_wdata(rf_wdata), .store_data(store_data),
		.read_word(read_word), .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
		.rf_waddr(rf_waddr), .byte_offset(byte_offset), .cif(cif.dp)
	);

	alu u_alu (
		.a(alu_a), .b(alu_b), .op(cif.alu_op), .result(alu_result), .zero(alu_zero)
	);

	reg_file u_reg_file (
		.clk(clk), .raddr1(rf_raddr1), .raddr2(rf_raddr2), .waddr(rf_waddr),
		.wen(cif.rf_wen), .wdata(rf_wdata), .rdata1(rs_data), .rdata2(rt_data)
	);

	mem_align u_mem_align (
		.byte_offset(byte_offset), .store_src(store_data), .read_word(read_word),
		.mem(cif.mem), .write_data(write_data), .write_strb(write_strb),
		.load_value(load_value)
	);

	assign retire_wen   = cif.rf_wen;
	assign retire_waddr = rf_waddr;
	assign retire_wdata = rf_wdata;
	assign retire_pc    = pc;

endmodule

/* tests/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst
);
	localparam int half_period = 2;   // 4 ns clock
	localparam int reset_cycles = 3;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* tests/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	typedef enum logic [1:0] {k_reg, k_load, k_store, k_flow} kind_t;
	typedef enum {ev_fetch, ev_instr, ev_store, ev_load, ev_rdata, ev_retire} wait_t;

	typedef struct {
		word_t     instr;
		word_t     reply;    // Read word handed back to a load
		kind_t     kind;
		reg_addr_t waddr;
		word_t     value;
		word_t     addr;
		word_t     data;
		logic [3:0] strb;
		word_t     pc;
		word_t     next_pc;
	} entry_t;

	localparam word_t start_pc = 32'h0000_0100;
	localparam int wait_limit = 50;

	logic       clk;
	logic       rst;
	logic       inst_req_valid;
	logic       inst_req_ready;
	word_t      pc;
	word_t      instruction;
	logic       inst_valid;
	logic       inst_ready;
	word_t      address;
	logic       mem_write;
	word_t      write_data;
	logic [3:0] write_strb;
	logic       mem_read;
	logic       mem_req_ready;
	word_t      read_data;
	logic       read_data_valid;
	logic       read_data_ready;
	logic       retire_wen;
	reg_addr_t  retire_waddr;
	word_t      retire_wdata;
	word_t      retire_pc;

	entry_t prog[$];
	word_t  model_regs [32];
	word_t  model_pc;

	clk_gen u_clk_gen (.clk(clk), .rst(rst));

	cpu_top #(.reset_pc(start_pc)) uut (
		.clk(clk), .rst(rst),
		.inst_req_valid(inst_req_valid), .inst_req_ready(inst_req_ready), .pc(pc),
		.instruction(instruction), .inst_valid(inst_valid), .inst_ready(inst_ready),
		.address(address), .mem_write(mem_write), .write_data(write_data),
		.write_strb(write_strb), .mem_read(mem_read), .mem_req_ready(mem_req_ready),
		.read_data(read_data), .read_data_valid(read_data_valid),
		.read_data_ready(read_data_ready), .retire_wen(retire_wen),
		.retire_waddr(retire_waddr), .retire_wdata(retire_wdata), .retire_pc(retire_pc)
	);

	function automatic word_t rtype(input logic [5:0] fn, input reg_addr_t rd,
			input reg_addr_t rs, input reg_addr_t rt);
		return {6'h00, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic word_t itype(input logic [5:0] op, input reg_addr_t rt,
			input reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jtype(input logic [25:0] index);
		return {6'h02, index};
	endfunction

	// MIPS reference model, fills in the expected results of one table entry
	task automatic add_entry(input word_t instr, input word_t reply);
		entry_t     e;
		logic [5:0] op;
		word_t      a;
		word_t      b;
		word_t      sx;
		word_t      zx;
		word_t      ea;
		word_t      pc4;
		word_t      shifted;
		logic [15:0] lane_h;
		op = instr[31:26];
		a = model_regs[instr[25:21]];
		b = model_regs[instr[20:16]];
		sx = {{16{instr[15]}}, instr[15:0]};
		zx = {16'h0000, instr[15:0]};
		ea = a + sx;
		pc4 = model_pc + 32'd4;
		shifted = reply >> (8 * ea[1:0]);
		lane_h = ea[1] ? reply[31:16] : reply[15:0];
		e.instr = instr;
		e.reply = reply;
		e.kind = k_reg;
		e.waddr = instr[20:16];
		e.value = '0;
		e.addr = {ea[31:2], 2'b00};
		e.data = '0;
		e.strb = '0;
		e.pc = model_pc;
		e.next_pc = pc4;
		if (instr == '0) begin
			e.kind = k_flow;
		end else begin
			case (op)
				6'h00: begin
					e.waddr = instr[15:11];
					case (instr[5:0])
						6'h21: e.value = a + b;
						6'h23: e.value = a - b;
						6'h24: e.value = a & b;
						6'h25: e.value = a | b;
						6'h26: e.value = a ^ b;
						6'h27: e.value = ~(a | b);
						6'h2a: e.value = {31'b0, $signed(a) < $signed(b)};
						default: e.value = {31'b0, a < b};
					endcase
				end
				6'h09: e.value = a + sx;
				6'h0a: e.value = {31'b0, $signed(a) < $signed(sx)};
				6'h0b: e.value = {31'b0, a < sx};
				6'h0c: e.value = a & zx;
				6'h0d: e.value = a | zx;
				6'h0e: e.value = a ^ zx;
				6'h0f: e.value = {instr[15:0], 16'h0000};
				6'h20, 6'h24: begin
					e.kind = k_load;
					e.value = (op == 6'h24) ? {24'b0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
				end
				6'h21, 6'h25: begin
					e.kind = k_load;
					e.value = (op == 6'h25) ? {16'b0, lane_h} : {{16{lane_h[15]}}, lane_h};
				end
				6'h23: begin
					e.kind = k_load;
					e.value = reply;
				end
				6'h28: begin
					e.kind = k_store;
					e.data = {4{b[7:0]}};
					e.strb = 4'b0001 << ea[1:0];
				end
				6'h29: begin
					e.kind = k_store;
					e.data = {2{b[15:0]}};
					e.strb = ea[1] ? 4'b1100 : 4'b0011;
				end
				6'h2b: begin
					e.kind = k_store;
					e.data = b;
					e.strb = 4'b1111;
				end
				6'h04, 6'h05: begin
					e.kind = k_flow;
					if ((a == b) == (op == 6'h04))
						e.next_pc = pc4 + {sx[29:0], 2'b00};
				end
				default: begin
					e.kind = k_flow;   // j
					e.next_pc = {pc4[31:28], instr[25:0], 2'b00};
				end
			endcase
		end
		if ((e.kind == k_reg || e.kind == k_load) && e.waddr != 5'd0)
			model_regs[e.waddr] = e.value;
		model_pc = e.next_pc;
		prog.push_back(e);
	endtask

	task automatic build_program();
		foreach (model_regs[i])
			model_regs[i] = '0;
		model_pc = start_pc;
		add_entry(itype(op_lui, 5'd1, 5'd0, 16'h8000), '0);
		add_entry(itype(op_ori, 5'd1, 5'd1, 16'h0005), '0);
		add_entry(itype(op_addiu, 5'd2, 5'd0, 16'hfffd), '0);
		add_entry(itype(op_addiu, 5'd3, 5'd0, 16'h0007), '0);
		add_entry(rtype(fn_addu, 5'd4, 5'd1, 5'd3), '0);
		add_entry(rtype(fn_subu, 5'd5, 5'd3, 5'd2), '0);
		add_entry(rtype(fn_and, 5'd6, 5'd1, 5'd2), '0);
		add_entry(rtype(fn_or, 5'd7, 5'd2, 5'd3), '0);
		add_entry(rtype(fn_xor, 5'd8, 5'd1, 5'd3), '0);
		add_entry(rtype(fn_nor, 5'd9, 5'd1, 5'd3), '0);
		add_entry(rtype(fn_slt, 5'd10, 5'd2, 5'd3), '0);    // Mixed signs
		add_entry(rtype(fn_sltu, 5'd11, 5'd2, 5'd3), '0);
		add_entry(rtype(fn_slt, 5'd24, 5'd3, 5'd1), '0);
		add_entry(itype(op_slti, 5'd12, 5'd1, 16'h0005), '0);
		add_entry(itype(op_sltiu, 5'd13, 5'd3, 16'hffff), '0);
		add_entry(itype(op_andi, 5'd14, 5'd2, 16'hf0f0), '0);
		add_entry(itype(op_xori, 5'd15, 5'd3, 16'hffff), '0);
		add_entry(itype(op_addiu, 5'd20, 5'd0, 16'h0200), '0);
		add_entry(itype(op_sw, 5'd1, 5'd20, 16'h0004), '0);
		add_entry(itype(op_sh, 5'd2, 5'd20, 16'h0006), '0);
		add_entry(itype(op_sb, 5'd3, 5'd20, 16'h0003), '0);
		add_entry(itype(op_sb, 5'd4, 5'd20, 16'h0005), '0);
		add_entry(itype(op_lw, 5'd16, 5'd20, 16'h0008), 32'hdead_beef);
		add_entry(itype(op_lh, 5'd17, 5'd20, 16'h0002), 32'h8001_1234);
		add_entry(itype(op_lhu, 5'd18, 5'd20, 16'h0000), 32'h1234_8765);
		add_entry(itype(op_lb, 5'd19, 5'd20, 16'h0001), 32'h1122_8344);
		add_entry(itype(op_lbu, 5'd21, 5'd20, 16'h0003), 32'hf0ab_cdef);
		add_entry(rtype(fn_addu, 5'd0, 5'd3, 5'd3), '0);     // Write to r0 is dropped
		add_entry(rtype(fn_addu, 5'd22, 5'd0, 5'd3), '0);
		add_entry(32'h0000_0000, '0);
		add_entry(itype(op_beq, 5'd3, 5'd3, 16'h0002), '0);
		add_entry(itype(op_beq, 5'd3, 5'd2, 16'h0001), '0);
		add_entry(itype(op_bne, 5'd3, 5'd2, 16'hfffe), '0);
		add_entry(itype(op_bne, 5'd3, 5'd3, 16'h0005), '0);
		add_entry(jtype(26'h000_0100), '0);
		add_entry(itype(op_addiu, 5'd23, 5'd22, 16'h0001), '0);
	endtask

	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at first failure");
	endtask

	task automatic word_check(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic reg_check(input string what, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is r%0d, expected r%0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic strb_check(input string what, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic bit_check(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	function automatic logic level_of(input wait_t what);
		case (what)
			ev_fetch:  return inst_req_valid;
			ev_instr:  return inst_ready;
			ev_store:  return mem_write;
			ev_load:   return mem_read;
			ev_rdata:  return read_data_ready;
			default:   return retire_wen;
		endcase
	endfunction

	// Outputs are sampled on the falling edge
	task automatic wait_for(input wait_t what);
		int count;
		count = 0;
		@(negedge clk);
		while (!level_of(what)) begin
			if (count == wait_limit) begin
				$display("Timed out at %0t ns waiting for %s", $time, what.name());
				abort_run();
			end else begin
				count++;
				@(negedge clk);
			end
		end
	endtask

	task automatic wait_reset_release();
		int count;
		count = 0;
		@(negedge clk);
		while (rst) begin
			if (count == wait_limit) begin
				$display("Reset was never released");
				abort_run();
			end else begin
				count++;
				@(negedge clk);
			end
		end
	endtask

	task automatic random_stall();
		int n;
		n = $urandom_range(0, 3);
		repeat (n) @(posedge clk);
	endtask

	task automatic grant_fetch();
		random_stall();
		@(posedge clk);
		inst_req_ready <= 1'b1;
		@(posedge clk);
		inst_req_ready <= 1'b0;   // Transfer took place on this edge
	endtask

	task automatic grant_mem();
		random_stall();
		@(posedge clk);
		mem_req_ready <= 1'b1;
		@(posedge clk);
		mem_req_ready <= 1'b0;
	endtask

	task automatic check_retire(input entry_t e);
		wait_for(ev_retire);
		reg_check("retire_waddr", retire_waddr, e.waddr);
		word_check("retire_wdata", retire_wdata, e.value);
		word_check("retire_pc", retire_pc, e.pc);
	endtask

	task automatic run_entry(input entry_t e);
		wait_for(ev_fetch);
		word_check("fetch pc", pc, e.pc);
		grant_fetch();
		wait_for(ev_instr);
		random_stall();
		@(posedge clk);
		instruction <= e.instr;
		inst_valid <= 1'b1;
		@(posedge clk);
		inst_valid <= 1'b0;
		case (e.kind)
			k_reg: check_retire(e);
			k_load: begin
				wait_for(ev_load);
				word_check("load address", address, e.addr);
				grant_mem();
				wait_for(ev_rdata);
				random_stall();
				@(posedge clk);
				read_data <= e.reply;
				read_data_valid <= 1'b1;
				@(posedge clk);
				read_data_valid <= 1'b0;
				check_retire(e);
			end
			k_store: begin
				wait_for(ev_store);
				word_check("store address", address, e.addr);
				word_check("store data", write_data, e.data);
				strb_check("store strobe", write_strb, e.strb);
				grant_mem();
			end
			default: begin
			end
		endcase
	endtask

	initial begin
		void'($urandom(69));
		inst_req_ready = 1'b0;
		instruction = '0;
		inst_valid = 1'b0;
		mem_req_ready = 1'b0;
		read_data = '0;
		read_data_valid = 1'b0;
		build_program();
		wait_reset_release();
		bit_check("inst_req_valid after reset", inst_req_valid, 1'b0);
		bit_check("mem_write after reset", mem_write, 1'b0);
		bit_check("mem_read after reset", mem_read, 1'b0);
		bit_check("retire_wen after reset", retire_wen, 1'b0);
		foreach (prog[i])
			run_entry(prog[i]);
		wait_for(ev_fetch);
		word_check("pc after last instruction", pc, prog[prog.size() - 1].next_pc);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* files.f */
verilog/cpu_pkg.sv
verilog/ctrl_if.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/mem_align.sv
verilog/exec_datapath.sv
verilog/cpu_control.sv
verilog/cpu_top.sv
tests/clk_gen.sv
tests/cpu_tb.sv
